//--- Bender.yml
package:
  name: pkt_fifo

sources:
  - hw/fifo_geom_pkg.sv
  - hw/fifo_word_pkg.sv
  - hw/pkt_fifo_write_ctrl.sv
  - hw/pkt_fifo_ram.sv
  - hw/pkt_fifo_read_ctrl.sv
  - hw/pkt_fifo_top.sv
  - target: test
    files:
      - tests/pkt_fifo_chk.sv
      - tests/pkt_fifo_tb.sv

//--- hw/fifo_geom_pkg.sv
`default_nettype none

package fifo_geom_pkg;

    // --------------------
    // FIFO geometry
    // --------------------

    // Number of stored words, must stay a power of two
    localparam int FIFO_DEPTH = 16;

    // Bits that index the memory
    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

    // Pointers carry one extra wrap bit to tell full from empty
    localparam int PTR_WIDTH = ADDR_WIDTH + 1;

    // Level spans 0 to FIFO_DEPTH inclusive
    localparam int LEVEL_WIDTH = $clog2(FIFO_DEPTH + 1);

    // Fixed flag thresholds
    localparam int ALMOST_FULL_LVL = 12;
    localparam int ALMOST_EMPTY_LVL = 2;

    // --------------------
    // Derived types
    // --------------------

    typedef logic [PTR_WIDTH-1:0] fifo_ptr_t;
    typedef logic [ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [LEVEL_WIDTH-1:0] fifo_lvl_t;

endpackage : fifo_geom_pkg

`default_nettype wire

//--- hw/fifo_word_pkg.sv
`default_nettype none

package fifo_word_pkg;

    // --------------------
    // Payload
    // --------------------

    // Width of one data word
    localparam int DATA_WIDTH = 16;

    typedef logic [DATA_WIDTH-1:0] data_t;

    // Stored word
    // Last flag sits on top so the memory holds the packet boundary too
    typedef struct packed {
        logic  last;
        data_t data;
    } fifo_word_t;

endpackage : fifo_word_pkg

`default_nettype wire

//--- hw/pkt_fifo_ram.sv
`default_nettype none

module pkt_fifo_ram
    import fifo_geom_pkg::*;
    import fifo_word_pkg::*;
(
    input  logic       clk,
    input  logic       wen,
    input  mem_addr_t  waddr,
    input  fifo_word_t wword,
    input  mem_addr_t  raddr,
    output fifo_word_t rword
);

    // Storage array, no reset so it maps to block RAM
    fifo_word_t mem [FIFO_DEPTH];

    // --------------------
    // Write port
    // --------------------

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wword;
        end
    end

    // --------------------
    // Read port
    // --------------------

    // Read on every edge
    // Collision on the same address returns the old word
    always_ff @(posedge clk) begin
        rword <= mem[raddr];
    end

endmodule : pkt_fifo_ram

`default_nettype wire

//--- hw/pkt_fifo_read_ctrl.sv
`default_nettype none

module pkt_fifo_read_ctrl
    import fifo_geom_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      rready,
    input  logic      rlast,
    input  fifo_ptr_t write_ptr,
    input  fifo_ptr_t write_ptr_next,
    input  logic      last_committed,
    output logic      rvalid,
    output mem_addr_t raddr,
    output fifo_ptr_t read_ptr,
    output logic      word_popped,
    output fifo_lvl_t level,
    output logic      walmost_full,
    output logic      ralmost_empty
);

    // Read handshake
    logic      read_hs;
    // Final word of a packet leaves
    logic      last_popped;
    fifo_ptr_t read_ptr_next;
    // Complete packets held in memory
    fifo_lvl_t pkt_cnt;
    fifo_lvl_t pkt_cnt_next;
    fifo_lvl_t level_next;
    logic      rvalid_next;

    assign read_hs = rvalid && rready;
    assign word_popped = read_hs;
    assign last_popped = read_hs && rlast;

    // --------------------
    // Read pointer
    // --------------------

    assign read_ptr_next = read_ptr + fifo_ptr_t'(read_hs);

    // Memory reads one edge ahead
    // rword then always shows the word at read_ptr
    assign raddr = read_ptr_next[ADDR_WIDTH-1:0];

    // --------------------
    // Packet counter
    // --------------------

    always_comb begin
        unique case ({last_committed, last_popped})
            2'b10: pkt_cnt_next = pkt_cnt + fifo_lvl_t'(1);
            2'b01: pkt_cnt_next = pkt_cnt - fifo_lvl_t'(1);
            // Idle, or one packet in and one out
            default: pkt_cnt_next = pkt_cnt;
        endcase
    end

    // Data guard on top of the count
    // A stored packet always leaves words between the pointers
    assign rvalid_next = (pkt_cnt_next != '0) && (read_ptr_next != write_ptr);

    // --------------------
    // Level and flags
    // --------------------

    // Pointer difference wraps cleanly thanks to the wrap bit
    assign level_next = write_ptr_next - read_ptr_next;

    assign walmost_full = (level >= fifo_lvl_t'(ALMOST_FULL_LVL));
    assign ralmost_empty = (level <= fifo_lvl_t'(ALMOST_EMPTY_LVL));

    // --------------------
    // Control registers
    // --------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            read_ptr <= '0;
            pkt_cnt <= '0;
            rvalid <= 1'b0;
            level <= '0;
        end else begin
            read_ptr <= read_ptr_next;
            pkt_cnt <= pkt_cnt_next;
            // Only whole packets are offered to the reader
            rvalid <= rvalid_next;
            level <= level_next;
        end
    end

endmodule : pkt_fifo_read_ctrl

`default_nettype wire

//--- hw/pkt_fifo_top.sv
`default_nettype none

module pkt_fifo_top
    import fifo_geom_pkg::*;
    import fifo_word_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    // Write side
    input  logic      wvalid,
    input  data_t     wdata,
    input  logic      wlast,
    input  logic      wdrop,
    output logic      wready,
    output logic      walmost_full,
    // Read side
    input  logic      rready,
    output logic      rvalid,
    output data_t     rdata,
    output logic      rlast,
    output logic      ralmost_empty,
    output fifo_lvl_t level
);

    // Write control to memory
    logic       wen;
    mem_addr_t  waddr;
    fifo_word_t wword;

    // Memory to read side
    mem_addr_t  raddr;
    fifo_word_t rword;

    // Between the two control stages
    fifo_ptr_t  write_ptr;
    fifo_ptr_t  write_ptr_next;
    logic       last_committed;
    fifo_ptr_t  read_ptr;
    logic       word_popped;

    // Stored word splits straight onto the read port
    assign rdata = rword.data;
    assign rlast = rword.last;

    // --------------------
    // Stages
    // --------------------

    pkt_fifo_write_ctrl u_write_ctrl (
        .clk            (clk),
        .arst_n         (arst_n),
        .wvalid         (wvalid),
        .wdata          (wdata),
        .wlast          (wlast),
        .wdrop          (wdrop),
        .read_ptr       (read_ptr),
        .word_popped    (word_popped),
        .wready         (wready),
        .wen            (wen),
        .waddr          (waddr),
        .wword          (wword),
        .write_ptr      (write_ptr),
        .write_ptr_next (write_ptr_next),
        .last_committed (last_committed)
    );

    pkt_fifo_ram u_ram (
        .clk   (clk),
        .wen   (wen),
        .waddr (waddr),
        .wword (wword),
        .raddr (raddr),
        .rword (rword)
    );

    // rlast also tells read control when a packet has left
    pkt_fifo_read_ctrl u_read_ctrl (
        .clk            (clk),
        .arst_n         (arst_n),
        .rready         (rready),
        .rlast          (rlast),
        .write_ptr      (write_ptr),
        .write_ptr_next (write_ptr_next),
        .last_committed (last_committed),
        .rvalid         (rvalid),
        .raddr          (raddr),
        .read_ptr       (read_ptr),
        .word_popped    (word_popped),
        .level          (level),
        .walmost_full   (walmost_full),
        .ralmost_empty  (ralmost_empty)
    );

endmodule : pkt_fifo_top

`default_nettype wire

//--- hw/pkt_fifo_write_ctrl.sv
`default_nettype none

module pkt_fifo_write_ctrl
    import fifo_geom_pkg::*;
    import fifo_word_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wvalid,
    input  data_t      wdata,
    input  logic       wlast,
    input  logic       wdrop,
    input  fifo_ptr_t  read_ptr,
    input  logic       word_popped,
    output logic       wready,
    output logic       wen,
    output mem_addr_t  waddr,
    output fifo_word_t wword,
    output fifo_ptr_t  write_ptr,
    output fifo_ptr_t  write_ptr_next,
    output logic       last_committed
);

    // Write handshake
    logic      write_hs;
    // Pointer after this cycle's write, ignoring a drop
    fifo_ptr_t write_ptr_adv;
    // First word of the packet being written
    fifo_ptr_t sop_ptr;
    // A last word was accepted and not dropped
    logic      last_write;
    logic      wready_next;

    assign write_hs = wvalid && wready;
    assign write_ptr_adv = write_ptr + fifo_ptr_t'(write_hs);

    // Drop rewinds to the packet start
    // A word accepted in the same cycle is thrown away with the rest
    assign write_ptr_next = wdrop ? sop_ptr : write_ptr_adv;

    assign last_write = write_hs && wlast && !wdrop;

    // --------------------
    // Readiness
    // --------------------

    // Full when address bits match and wrap bits differ
    // A pop this cycle always frees a slot for the next one
    assign wready_next =
        (read_ptr[ADDR_WIDTH-1:0] != write_ptr_next[ADDR_WIDTH-1:0]) ||
        (read_ptr[PTR_WIDTH-1] == write_ptr_next[PTR_WIDTH-1]) ||
        word_popped;

    // --------------------
    // Memory write port
    // --------------------

    assign wen = write_hs;
    assign waddr = write_ptr[ADDR_WIDTH-1:0];
    assign wword = '{last: wlast, data: wdata};

    // --------------------
    // Control registers
    // --------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            write_ptr <= '0;
            sop_ptr <= '0;
            wready <= 1'b0;
            last_committed <= 1'b0;
        end else begin
            write_ptr <= write_ptr_next;
            // Next packet starts right after a committed last
            if (last_write) begin
                sop_ptr <= write_ptr_next;
            end
            wready <= wready_next;
            // One cycle late so the memory holds the word before the reader counts it
            last_committed <= last_write;
        end
    end

endmodule : pkt_fifo_write_ctrl

`default_nettype wire

//--- tests/pkt_fifo_chk.sv
`default_nettype none

module pkt_fifo_chk
    import fifo_geom_pkg::*;
    import fifo_word_pkg::*;
(
    input logic      clk,
    input logic      arst_n,
    input logic      wvalid,
    input logic      wready,
    input logic      rvalid,
    input logic      rready,
    input data_t     rdata,
    input logic      rlast,
    input fifo_lvl_t level
);

    // Number of failed assertions, read back by the testbench
    int fail_count = 0;

    // --------------------
    // Write side
    // --------------------

    // A full FIFO accepts nothing
    no_write_when_full: assert property (
        @(posedge clk) disable iff (!arst_n)
        (level == fifo_lvl_t'(FIFO_DEPTH)) |-> !(wvalid && wready)
    ) else begin
        fail_count++;
        $error("write accepted while level is FIFO_DEPTH");
    end

    level_in_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        level <= fifo_lvl_t'(FIFO_DEPTH)
    ) else begin
        fail_count++;
        $error("level above FIFO_DEPTH");
    end

    // --------------------
    // Read side
    // --------------------

    // Stalled word stays on the port
    read_word_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rlast))
    ) else begin
        fail_count++;
        $error("read word changed while stalled");
    end

    valid_needs_data: assert property (
        @(posedge clk) disable iff (!arst_n)
        rvalid |-> (level != '0)
    ) else begin
        fail_count++;
        $error("rvalid high with level zero");
    end

endmodule : pkt_fifo_chk

// Checker sits inside every FIFO top level
bind pkt_fifo_top pkt_fifo_chk u_chk (
    .clk    (clk),
    .arst_n (arst_n),
    .wvalid (wvalid),
    .wready (wready),
    .rvalid (rvalid),
    .rready (rready),
    .rdata  (rdata),
    .rlast  (rlast),
    .level  (level)
);

`default_nettype wire

//--- tests/pkt_fifo_tb.sv
`default_nettype none

module pkt_fifo_tb
    import fifo_geom_pkg::*;
    import fifo_word_pkg::*;
();

    localparam logic [31:0] LFSR_SEED = 32'h5716_f87e;
    localparam int TRACE_MAX = 512;

    logic      clk;
    logic      arst_n;
    logic      wvalid;
    data_t     wdata;
    logic      wlast;
    logic      wdrop;
    logic      wready;
    logic      walmost_full;
    logic      rready;
    logic      rvalid;
    data_t     rdata;
    logic      rlast;
    logic      ralmost_empty;
    fifo_lvl_t level;

    // Raw trace words and what is parsed out of them
    logic [15:0] trace_mem [TRACE_MAX];
    int          pkt_len[$];
    int          pkt_drop[$];
    data_t       pkt_data[$];
    data_t       exp_data[$];
    logic        exp_last[$];
    int          fill_count;
    data_t       fill_base;

    // Gap generator state, one bit per side each cycle
    logic [31:0] lfsr;
    logic        wr_go;
    logic        rd_go;

    int checks_done;
    int errors_found;
    int limit_cycles;

    pkt_fifo_top dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .wvalid        (wvalid),
        .wdata         (wdata),
        .wlast         (wlast),
        .wdrop         (wdrop),
        .wready        (wready),
        .walmost_full  (walmost_full),
        .rready        (rready),
        .rvalid        (rvalid),
        .rdata         (rdata),
        .rlast         (rlast),
        .ralmost_empty (ralmost_empty),
        .level         (level)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------
    // Helpers
    // --------------------

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic take_bit();
        logic b;
        b = lfsr[31];
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return b;
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks_done++;
        assert (actual == expected) else begin
            errors_found++;
            $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic load_trace();
        int idx;
        int i;
        int n;
        $readmemh("tests/pkt_fifo_trace.txt", trace_mem);
        idx = 0;
        // Packets up to the zero length mark
        while (idx < TRACE_MAX && trace_mem[idx] != 16'h0) begin
            pkt_len.push_back(trace_mem[idx]);
            pkt_drop.push_back(trace_mem[idx + 1]);
            for (i = 0; i < trace_mem[idx]; i++) begin
                pkt_data.push_back(trace_mem[idx + 2 + i]);
            end
            idx += 2 + trace_mem[idx];
        end
        // Expected stream after the mark
        n = trace_mem[idx + 1];
        for (i = 0; i < n; i++) begin
            exp_data.push_back(trace_mem[idx + 2 + 2 * i]);
            exp_last.push_back(trace_mem[idx + 3 + 2 * i][0]);
        end
        idx += 2 + 2 * n;
        fill_count = trace_mem[idx];
        fill_base = trace_mem[idx + 1];
        limit_cycles = 40 * (pkt_data.size() + fill_count) + 500;
        assert (pkt_len.size() > 0 && exp_data.size() > 0) else begin
            errors_found++;
            $display("Trace file is missing or holds no packets");
        end
    endtask

    // Offer one word until it is taken
    task automatic push_word(input data_t d, input logic l, input logic gaps);
        logic done;
        done = 1'b0;
        while (!done) begin
            wvalid = gaps ? wr_go : 1'b1;
            wdata = d;
            wlast = l;
            // wready is registered, so this is the value at the coming edge
            done = wvalid && wready;
            @(posedge clk);
            #1;
        end
        wvalid = 1'b0;
    endtask

    task automatic pop_word(output data_t d, output logic l, input logic gaps);
        logic done;
        done = 1'b0;
        while (!done) begin
            rready = gaps ? rd_go : 1'b1;
            done = rready && rvalid;
            d = rdata;
            l = rlast;
            @(posedge clk);
            #1;
        end
        rready = 1'b0;
    endtask

    task automatic drop_packet();
        wdrop = 1'b1;
        @(posedge clk);
        #1;
        wdrop = 1'b0;
    endtask

    // --------------------
    // Test phases
    // --------------------

    task automatic check_reset_values();
        int n;
        check_value("rvalid after reset", rvalid, 0);
        check_value("walmost_full after reset", walmost_full, 0);
        check_value("level after reset", level, 0);
        check_value("ralmost_empty after reset", ralmost_empty, 1);
        for (n = 0; n < 2 && wready !== 1'b1; n++) begin
            @(posedge clk);
            #1;
        end
        check_value("wready two edges after reset", wready, 1);
    endtask

    // First packet goes in word by word while the reader waits
    task automatic partial_packet();
        int i;
        int n;
        rready = 1'b1;
        for (i = 0; i < pkt_len[0] - 1; i++) begin
            push_word(pkt_data[i], 1'b0, 1'b0);
            check_value("rvalid with partial packet", rvalid, 0);
        end
        repeat (3) begin
            @(posedge clk);
            #1;
            check_value("rvalid with partial packet", rvalid, 0);
        end
        rready = 1'b0;
        push_word(pkt_data[pkt_len[0] - 1], 1'b1, 1'b0);
        for (n = 0; n < 4 && rvalid !== 1'b1; n++) begin
            @(posedge clk);
            #1;
        end
        check_value("rvalid after last word", rvalid, 1);
        check_value("rdata of first stored word", rdata, pkt_data[0]);
    endtask

    task automatic write_packets();
        int base;
        int p;
        int i;
        base = pkt_len[0];
        for (p = 1; p < pkt_len.size(); p++) begin
            for (i = 0; i < pkt_len[p]; i++) begin
                push_word(pkt_data[base + i], i == pkt_len[p] - 1, 1'b1);
                if (i == pkt_drop[p]) begin
                    drop_packet();
                    break;
                end
            end
            base += pkt_len[p];
        end
    endtask

    task automatic read_stream();
        data_t d;
        logic  l;
        int    i;
        for (i = 0; i < exp_data.size(); i++) begin
            pop_word(d, l, 1'b1);
            check_value($sformatf("rdata of word %0d", i), d, exp_data[i]);
            check_value($sformatf("rlast of word %0d", i), l, exp_last[i]);
        end
    endtask

    task automatic fill_and_drain();
        data_t d;
        logic  l;
        int    i;
        int    left;
        rready = 1'b0;
        for (i = 0; i < fill_count; i++) begin
            push_word(fill_base + data_t'(i), i == fill_count - 1, 1'b0);
            check_value("level while filling", level, i + 1);
        end
        check_value("wready when full", wready, 0);
        check_value("walmost_full when full", walmost_full, 1);
        // One more word waits on a full FIFO and is never taken
        wvalid = 1'b1;
        wdata = fill_base + data_t'(fill_count);
        wlast = 1'b1;
        repeat (3) begin
            @(posedge clk);
            #1;
            check_value("wready while full and offered", wready, 0);
            check_value("level while full and offered", level, FIFO_DEPTH);
        end
        wvalid = 1'b0;
        for (i = 0; i < fill_count; i++) begin
            pop_word(d, l, 1'b0);
            left = fill_count - 1 - i;
            check_value("rdata while draining", d, fill_base + data_t'(i));
            check_value("rlast while draining", l, i == fill_count - 1);
            check_value("level while draining", level, left);
            check_value("ralmost_empty while draining", ralmost_empty,
                        left <= ALMOST_EMPTY_LVL);
            check_value("walmost_full while draining", walmost_full,
                        left >= ALMOST_FULL_LVL);
            if (i == 0) begin
                check_value("wready after first read", wready, 1);
            end
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------

    // Both gap bits change on the edge, drivers read them 1 unit later
    initial begin
        lfsr = LFSR_SEED;
        wr_go = 1'b1;
        rd_go = 1'b1;
        forever begin
            @(posedge clk);
            wr_go = take_bit();
            rd_go = take_bit();
        end
    end

    initial begin
        arst_n = 1'b0;
        wvalid = 1'b0;
        wdata = '0;
        wlast = 1'b0;
        wdrop = 1'b0;
        rready = 1'b0;
        load_trace();
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_reset_values();
        if (pkt_len.size() > 0) begin
            partial_packet();
            fork
                write_packets();
                read_stream();
            join
            check_value("level after stream", level, 0);
            check_value("rvalid after stream", rvalid, 0);
            fill_and_drain();
        end
        $display("Summary: %0d checks, %0d check errors, %0d assertion failures",
                 checks_done, errors_found, dut.u_chk.fail_count);
        if (errors_found == 0 && dut.u_chk.fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog, armed once the trace length is known
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: run did not end within %0d cycles", limit_cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule : pkt_fifo_tb

`default_nettype wire

//--- tests/pkt_fifo_trace.txt
// Packet lines: length, drop index (ffff keeps the packet), payload words
// Drop index names the word after which wdrop fires; a zero length ends the packets
0004 ffff 0a01 0a02 0a03 0a04
0003 ffff 0b01 0b02 0b03
0005 0001 0c01 0c02 0c03 0c04 0c05
0001 ffff 0d01
0006 ffff 0e01 0e02 0e03 0e04 0e05 0e06
0004 0002 0f01 0f02 0f03 0f04
0002 ffff 1001 1002
0007 ffff 1101 1102 1103 1104 1105 1106 1107
0003 0000 1201 1202 1203
0005 ffff 1301 1302 1303 1304 1305
0000
// Expected read stream: word count, then payload and last pairs
001c
0a01 0 0a02 0 0a03 0 0a04 1
0b01 0 0b02 0 0b03 1
0d01 1
0e01 0 0e02 0 0e03 0 0e04 0 0e05 0 0e06 1
1001 0 1002 1
1101 0 1102 0 1103 0 1104 0 1105 0 1106 0 1107 1
1301 0 1302 0 1303 0 1304 0 1305 1
// Fill phase: word count, first payload
0010 2000

//--- vlog.f
hw/fifo_geom_pkg.sv
hw/fifo_word_pkg.sv
hw/pkt_fifo_write_ctrl.sv
hw/pkt_fifo_ram.sv
hw/pkt_fifo_read_ctrl.sv
hw/pkt_fifo_top.sv
tests/pkt_fifo_chk.sv
tests/pkt_fifo_tb.sv
